// File: cart_bank_map.sv
// Stage 2 of the request pipeline
// Bank registers and ROM address translation

`timescale 1ns/100ps

module cart_bank_map (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 d2m_valid,
	output logic                 d2m_ready,
	input  cart_pkg::req_kind_e  d2m_kind,
	input  cart_pkg::bus_addr_t  d2m_addr,
	input  cart_pkg::word_t      d2m_wdata,
	input  cart_pkg::rom_addr_t  rom_mask,
	output logic                 m2s_valid,
	input  logic                 m2s_ready,
	output cart_pkg::req_kind_e  m2s_kind,
	output cart_pkg::rom_addr_t  m2s_rom_addr,
	output cart_pkg::sram_addr_t m2s_sram_addr,
	output cart_pkg::word_t      m2s_wdata
);

	import cart_pkg::*;

	bank_t                 bank [2**SLOT_SEL_W];
	logic                  banks_used;
	logic                  advance;
	logic                  is_bank;
	logic [SLOT_SEL_W-1:0] slot;
	rom_addr_t             mapped;

	assign d2m_ready = ~m2s_valid | m2s_ready;
	assign advance   = d2m_valid & d2m_ready;
	assign is_bank   = (d2m_kind == KIND_BANK_WRITE);
	assign slot      = d2m_addr[SLOT_AW +: SLOT_SEL_W];

	// Identity until the first bank write
	assign mapped = banks_used ? {bank[slot], d2m_addr[SLOT_AW-1:0]} : d2m_addr[ROM_AW-1:0];

	// ==============================
	// Bank registers
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**SLOT_SEL_W; i++)
				bank[i] <= bank_t'(i);
			banks_used <= 1'b0;
			m2s_valid  <= 1'b0;
		end else begin
			if (advance && is_bank) begin
				bank[d2m_addr[SLOT_SEL_W-1:0]] <= d2m_wdata[BANK_W-1:0];
				banks_used <= 1'b1;
			end
			// Bank writes end here
			if (d2m_ready)
				m2s_valid <= d2m_valid & ~is_bank;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && !is_bank) begin
			m2s_kind      <= d2m_kind;
			m2s_rom_addr  <= mapped & rom_mask;
			m2s_sram_addr <= d2m_addr[SRAM_AW-1:0];
			m2s_wdata     <= d2m_wdata;
		end
	end

endmodule

// File: cart_decode.sv
// Stage 1 of the request pipeline
// Request classification and the SRAM enable register

`timescale 1ns/100ps

module cart_decode (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 dl_active,
	input  logic                 req_valid,
	output logic                 req_ready,
	input  logic                 req_write,
	input  logic                 req_reg,
	input  cart_pkg::bus_addr_t  req_addr,
	input  cart_pkg::word_t      req_wdata,
	input  cart_pkg::rom_size_t  rom_size,
	input  logic                 sram_quirk,
	input  logic                 noram_quirk,
	output logic                 d2m_valid,
	input  logic                 d2m_ready,
	output cart_pkg::req_kind_e  d2m_kind,
	output cart_pkg::bus_addr_t  d2m_addr,
	output cart_pkg::word_t      d2m_wdata
);

	import cart_pkg::*;

	logic      live;
	logic      d2m_free;
	logic      accept;
	logic      sram_enable;
	logic      sram_win;
	logic      sram_hit;
	logic      keep;
	logic      enable_wr;
	req_kind_e kind;

	// Held off for one cycle after reset
	assign d2m_free  = ~d2m_valid | d2m_ready;
	assign req_ready = live & ~dl_active & d2m_free;
	assign accept    = req_valid & req_ready;

	assign sram_win = (req_addr >= bus_addr_t'(SRAM_BASE)) &&
		(req_addr < bus_addr_t'(SRAM_BASE + 2**SRAM_AW));
	assign sram_hit = (sram_win && (sram_enable ||
		(~noram_quirk && rom_size <= rom_size_t'(SRAM_BASE)))) ||
		(sram_quirk && req_addr == bus_addr_t'(SRAM_QUIRK_ADDR));

	// ==============================
	// Classification
	// ==============================
	always_comb begin
		kind      = KIND_OPEN_READ;
		keep      = 1'b0;
		enable_wr = 1'b0;
		if (req_reg && req_write) begin
			// Large images use registers 1-7 for banking
			if (rom_size > rom_size_t'(ROM_WINDOW_WORDS) && req_addr[2:0] != 3'd0) begin
				kind = KIND_BANK_WRITE;
				keep = 1'b1;
			end else begin
				enable_wr = 1'b1;
			end
		end else if (req_addr < bus_addr_t'(ROM_WINDOW_WORDS)) begin
			kind = KIND_ROM_READ;
			keep = ~req_write;
		end else if (sram_hit) begin
			kind = req_write ? KIND_SRAM_WRITE : KIND_SRAM_READ;
			keep = 1'b1;
		end else begin
			keep = ~req_write;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			live        <= 1'b0;
			d2m_valid   <= 1'b0;
			sram_enable <= 1'b0;
		end else begin
			live <= 1'b1;
			if (d2m_free)
				d2m_valid <= accept & keep;
			if (accept && enable_wr)
				sram_enable <= req_wdata[0];
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			d2m_kind  <= kind;
			d2m_addr  <= req_addr;
			d2m_wdata <= req_wdata;
		end
	end

endmodule

// File: cart_loader.sv
// Download capture
// ROM write stream, image size and address mask, header ID quirks

`timescale 1ns/100ps

module cart_loader (
	input  logic                clk,
	input  logic                reset,
	input  logic                dl_active,
	input  logic                dl_valid,
	input  cart_pkg::rom_addr_t dl_addr,
	input  cart_pkg::word_t     dl_data,
	output logic                rom_we,
	output cart_pkg::rom_addr_t rom_waddr,
	output cart_pkg::word_t     rom_wdata,
	output cart_pkg::rom_size_t rom_size,
	output cart_pkg::rom_addr_t rom_mask,
	output logic                sram_quirk,
	output logic                noram_quirk
);

	import cart_pkg::*;

	logic        dl_active_q;
	logic        dl_start;
	logic        dl_write;
	rom_size_t   size_base;
	rom_addr_t   mask_base;
	logic [63:0] cart_id;

	// Rising edge of dl_active starts a new image
	assign dl_start = dl_active & ~dl_active_q;
	assign dl_write = dl_active & dl_valid;

	// A word on the first cycle counts against a cleared image
	assign size_base = dl_start ? '0 : rom_size;
	assign mask_base = dl_start ? '0 : rom_mask;

	// ==============================
	// Size, mask and quirks
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			rom_we      <= 1'b0;
			rom_size    <= '0;
			rom_mask    <= '0;
			sram_quirk  <= 1'b0;
			noram_quirk <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			rom_we      <= dl_write;

			if (dl_start) begin
				rom_size    <= '0;
				rom_mask    <= '0;
				sram_quirk  <= 1'b0;
				noram_quirk <= 1'b0;
			end

			if (dl_write) begin
				rom_size <= size_base + rom_size_t'(1);
				rom_mask <= mask_base | dl_addr;

				// ID is complete once the word after it arrives
				if (dl_addr == rom_addr_t'(ID_DONE_WORD)) begin
					sram_quirk  <= (cart_id == ID_SRAM_0) || (cart_id == ID_SRAM_1);
					noram_quirk <= (cart_id == ID_NORAM);
				end
			end
		end
	end

	// ==============================
	// ROM write port and ID capture
	// ==============================
	always_ff @(posedge clk) begin
		if (dl_write) begin
			rom_waddr <= dl_addr;
			rom_wdata <= dl_data;
		end
	end

	// High byte of each word is the earlier character
	always_ff @(posedge clk) begin
		if (dl_write) begin
			for (int i = 0; i < ID_WORDS; i++) begin
				if (dl_addr == rom_addr_t'(ID_FIRST_WORD + i))
					cart_id[(ID_WORDS - 1 - i) * 16 +: 16] <= dl_data;
			end
		end
	end

endmodule

// File: cart_mem_stage.sv
// Stage 3 of the request pipeline
// ROM and SRAM arrays with the registered read response

`timescale 1ns/100ps

module cart_mem_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rom_we,
	input  cart_pkg::rom_addr_t  rom_waddr,
	input  cart_pkg::word_t      rom_wdata,
	input  logic                 m2s_valid,
	output logic                 m2s_ready,
	input  cart_pkg::req_kind_e  m2s_kind,
	input  cart_pkg::rom_addr_t  m2s_rom_addr,
	input  cart_pkg::sram_addr_t m2s_sram_addr,
	input  cart_pkg::word_t      m2s_wdata,
	output logic                 rsp_valid,
	input  logic                 rsp_ready,
	output cart_pkg::word_t      rsp_data
);

	import cart_pkg::*;

	word_t rom_mem  [2**ROM_AW];
	byte_t sram_mem [2**SRAM_AW];
	logic  advance;
	logic  is_read;

	assign m2s_ready = ~rsp_valid | rsp_ready;
	assign advance   = m2s_valid & m2s_ready;
	assign is_read   = (m2s_kind != KIND_SRAM_WRITE);

	// ==============================
	// Arrays
	// ==============================

	// Download side has its own write port
	always_ff @(posedge clk) begin
		if (rom_we)
			rom_mem[rom_waddr] <= rom_wdata;
	end

	// Battery SRAM keeps the low byte only
	always_ff @(posedge clk) begin
		if (advance && m2s_kind == KIND_SRAM_WRITE)
			sram_mem[m2s_sram_addr] <= m2s_wdata[7:0];
	end

	// ==============================
	// Response
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else if (m2s_ready) begin
			rsp_valid <= m2s_valid & is_read;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			case (m2s_kind)
				KIND_ROM_READ: begin
					rsp_data <= rom_mem[m2s_rom_addr];
				end
				KIND_SRAM_READ: begin
					// Byte shows on both halves of the bus
					rsp_data <= {sram_mem[m2s_sram_addr], sram_mem[m2s_sram_addr]};
				end
				KIND_OPEN_READ: begin
					rsp_data <= '1;
				end
				default: begin
					rsp_data <= rsp_data;
				end
			endcase
		end
	end

endmodule

// File: cart_pipe_chk.sv
// Handshake assertions bound into the cartridge top level
// Response hold under stall, request block during download, reset state

`timescale 1ns/100ps

module cart_pipe_chk (
	input logic            clk,
	input logic            reset,
	input logic            dl_active,
	input logic            req_ready,
	input logic            rsp_valid,
	input logic            rsp_ready,
	input cart_pkg::word_t rsp_data
);

	int unsigned fail_count = 0;

	// A stalled response must not move
	property rsp_held;
		@(posedge clk) disable iff (reset)
			rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data);
	endproperty

	property req_blocked_in_download;
		@(posedge clk) disable iff (reset) dl_active |-> !req_ready;
	endproperty

	property rsp_idle_after_reset;
		@(posedge clk) reset |=> !rsp_valid;
	endproperty

	a_rsp_held: assert property (rsp_held)
		else begin
			$error("Response changed while rsp_ready was low");
			fail_count++;
		end

	a_req_blocked: assert property (req_blocked_in_download)
		else begin
			$error("Request accepted during a download");
			fail_count++;
		end

	a_rsp_reset: assert property (rsp_idle_after_reset)
		else begin
			$error("Response valid right after reset");
			fail_count++;
		end

endmodule

bind cart_top cart_pipe_chk u_pipe_chk (
	.clk(clk), .reset(reset), .dl_active(dl_active), .req_ready(req_ready),
	.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data)
);

// File: cart_pkg.sv
// Cartridge package
// Scaled address space, data types, title IDs and request kinds

package cart_pkg;

	// ==============================
	// Address space
	// ==============================
	localparam int ROM_AW           = 14;
	localparam int SLOT_AW          = 10;
	localparam int SLOT_SEL_W       = 3;
	localparam int BANK_W           = 4;
	localparam int SRAM_AW          = 10;

	// Eight slots of 1K words
	localparam int ROM_WINDOW_WORDS = 8192;
	localparam int SRAM_BASE        = 8192;
	// Low SRAM_AW bits select the SRAM byte
	localparam int SRAM_QUIRK_ADDR  = 16383;

	// ==============================
	// Header ID
	// ==============================
	localparam int ID_FIRST_WORD    = 193;
	localparam int ID_WORDS         = 4;
	localparam int ID_DONE_WORD     = 197;

	// Titles that force the SRAM alias
	localparam logic [63:0] ID_SRAM_0 = "T-081276";
	localparam logic [63:0] ID_SRAM_1 = "T-81406 ";
	// Title that probes for missing RAM
	localparam logic [63:0] ID_NORAM  = "T-113016";

	// ==============================
	// Types
	// ==============================
	typedef logic [22:0]         bus_addr_t;
	typedef logic [15:0]         word_t;
	typedef logic [7:0]          byte_t;
	typedef logic [ROM_AW-1:0]   rom_addr_t;
	typedef logic [SRAM_AW-1:0]  sram_addr_t;
	typedef logic [BANK_W-1:0]   bank_t;
	typedef logic [ROM_AW:0]     rom_size_t;

	typedef enum logic [2:0] {
		KIND_ROM_READ,
		KIND_SRAM_READ,
		KIND_SRAM_WRITE,
		KIND_BANK_WRITE,
		KIND_OPEN_READ
	} req_kind_e;

endpackage

// File: cart_top.sv
// Cartridge engine top level
// Loader and the three request pipeline stages

`timescale 1ns/100ps

module cart_top (
	input  logic                clk,
	input  logic                reset,
	input  logic                dl_active,
	input  logic                dl_valid,
	input  cart_pkg::rom_addr_t dl_addr,
	input  cart_pkg::word_t     dl_data,
	input  logic                req_valid,
	output logic                req_ready,
	input  logic                req_write,
	input  logic                req_reg,
	input  cart_pkg::bus_addr_t req_addr,
	input  cart_pkg::word_t     req_wdata,
	output logic                rsp_valid,
	input  logic                rsp_ready,
	output cart_pkg::word_t     rsp_data
);

	import cart_pkg::*;

	// Download results
	logic       rom_we;
	rom_addr_t  rom_waddr;
	word_t      rom_wdata;
	rom_size_t  rom_size;
	rom_addr_t  rom_mask;
	logic       sram_quirk;
	logic       noram_quirk;

	// Stage links
	logic       d2m_valid;
	logic       d2m_ready;
	req_kind_e  d2m_kind;
	bus_addr_t  d2m_addr;
	word_t      d2m_wdata;
	logic       m2s_valid;
	logic       m2s_ready;
	req_kind_e  m2s_kind;
	rom_addr_t  m2s_rom_addr;
	sram_addr_t m2s_sram_addr;
	word_t      m2s_wdata;

	cart_loader u_loader (
		.clk(clk), .reset(reset),
		.dl_active(dl_active), .dl_valid(dl_valid), .dl_addr(dl_addr), .dl_data(dl_data),
		.rom_we(rom_we), .rom_waddr(rom_waddr), .rom_wdata(rom_wdata),
		.rom_size(rom_size), .rom_mask(rom_mask),
		.sram_quirk(sram_quirk), .noram_quirk(noram_quirk)
	);

	cart_decode u_decode (
		.clk(clk), .reset(reset), .dl_active(dl_active),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_reg(req_reg), .req_addr(req_addr), .req_wdata(req_wdata),
		.rom_size(rom_size), .sram_quirk(sram_quirk), .noram_quirk(noram_quirk),
		.d2m_valid(d2m_valid), .d2m_ready(d2m_ready), .d2m_kind(d2m_kind),
		.d2m_addr(d2m_addr), .d2m_wdata(d2m_wdata)
	);

	cart_bank_map u_bank_map (
		.clk(clk), .reset(reset),
		.d2m_valid(d2m_valid), .d2m_ready(d2m_ready), .d2m_kind(d2m_kind),
		.d2m_addr(d2m_addr), .d2m_wdata(d2m_wdata), .rom_mask(rom_mask),
		.m2s_valid(m2s_valid), .m2s_ready(m2s_ready), .m2s_kind(m2s_kind),
		.m2s_rom_addr(m2s_rom_addr), .m2s_sram_addr(m2s_sram_addr), .m2s_wdata(m2s_wdata)
	);

	cart_mem_stage u_mem_stage (
		.clk(clk), .reset(reset),
		.rom_we(rom_we), .rom_waddr(rom_waddr), .rom_wdata(rom_wdata),
		.m2s_valid(m2s_valid), .m2s_ready(m2s_ready), .m2s_kind(m2s_kind),
		.m2s_rom_addr(m2s_rom_addr), .m2s_sram_addr(m2s_sram_addr), .m2s_wdata(m2s_wdata),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data)
	);

endmodule

// File: filelist.f
cart_pkg.sv
cart_loader.sv
cart_decode.sv
cart_bank_map.sv
cart_mem_stage.sv
cart_top.sv
cart_pipe_chk.sv
tb_cart.sv

// File: tb_cart.sv
// Cartridge engine testbench
// Random images and bus requests checked against a reference model

`timescale 1ns/100ps

module tb_cart;

	import cart_pkg::*;

	localparam int LEN_SMALL   = 1024;
	localparam int LEN_MID     = 2048;
	localparam int LEN_LARGE   = 16384;
	localparam int DL_TOTAL    = 2 * LEN_SMALL + LEN_MID + 2 * LEN_LARGE;
	localparam int REQ_TOTAL   = 3100;
	localparam int CYCLE_LIMIT = DL_TOTAL + 4 * REQ_TOTAL + 100000;
	localparam int OPEN_BASE   = SRAM_BASE + 2**SRAM_AW;

	logic        clk;
	logic        reset;
	logic        dl_active;
	logic        dl_valid;
	rom_addr_t   dl_addr;
	word_t       dl_data;
	logic        req_valid;
	logic        req_ready;
	logic        req_write;
	logic        req_reg;
	bus_addr_t   req_addr;
	word_t       req_wdata;
	logic        rsp_valid;
	logic        rsp_ready;
	word_t       rsp_data;

	// Reference model state
	word_t       m_rom [2**ROM_AW];
	byte_t       m_sram [2**SRAM_AW];
	bank_t       m_bank [8];
	logic        m_banks_used;
	logic        m_sram_en;
	logic        m_sram_quirk;
	logic        m_noram_quirk;
	int          m_size;
	rom_addr_t   m_mask;
	word_t       exp_q [$];

	logic        stall_on;
	int          errors;
	int          n_checks;
	int          cycles;

	cart_top dut (
		.clk(clk), .reset(reset),
		.dl_active(dl_active), .dl_valid(dl_valid), .dl_addr(dl_addr), .dl_data(dl_data),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_reg(req_reg), .req_addr(req_addr), .req_wdata(req_wdata),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data)
	);

	always #2 clk = ~clk;

	// ==============================
	// Response monitor and watchdog
	// ==============================
	always @(posedge clk) begin
		if (!reset && rsp_valid && rsp_ready) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Response arrived at %0t with no read outstanding", $time);
			end else begin
				check_word(rsp_data, exp_q.pop_front(), "read data");
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Run hung: no finish after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic check_word(input word_t got, input word_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Advance to the next falling edge, where inputs change
	task automatic next_cycle();
		@(posedge clk);
		@(negedge clk);
		rsp_ready = stall_on ? (($urandom % 4) != 0) : 1'b1;
	endtask

	// ==============================
	// Reference model
	// ==============================
	function automatic word_t rom_word(input bus_addr_t addr);
		rom_addr_t a;
		a = addr[ROM_AW-1:0];
		if (m_banks_used)
			a = {m_bank[addr[12:10]], addr[9:0]};
		return m_rom[a & m_mask];
	endfunction

	task automatic predict_request(input logic write, input logic reg_strobe,
			input bus_addr_t addr, input word_t wdata);
		logic in_win;
		logic sram;
		in_win = (addr >= SRAM_BASE) && (addr < OPEN_BASE);
		sram = (in_win && (m_sram_en || (!m_noram_quirk && m_size <= SRAM_BASE))) ||
			(m_sram_quirk && addr == SRAM_QUIRK_ADDR);
		if (reg_strobe && write) begin
			if (m_size > ROM_WINDOW_WORDS && addr[2:0] != 3'd0) begin
				m_bank[addr[2:0]] = wdata[3:0];
				m_banks_used = 1'b1;
			end else begin
				m_sram_en = wdata[0];
			end
		end else if (addr < ROM_WINDOW_WORDS) begin
			if (!write)
				exp_q.push_back(rom_word(addr));
		end else if (sram) begin
			if (write)
				m_sram[addr[9:0]] = wdata[7:0];
			else
				exp_q.push_back({2{m_sram[addr[9:0]]}});
		end else if (!write) begin
			exp_q.push_back(16'hffff);
		end
	endtask

	// ==============================
	// Stimulus
	// ==============================
	task automatic send_req(input logic write, input logic reg_strobe,
			input bus_addr_t addr, input word_t wdata);
		logic taken;
		taken = 1'b0;
		req_valid = 1'b1;
		req_write = write;
		req_reg = reg_strobe;
		req_addr = addr;
		req_wdata = wdata;
		while (!taken) begin
			// Ready is settled well before the rising edge
			#1;
			taken = req_ready;
			next_cycle();
		end
		req_valid = 1'b0;
		predict_request(write, reg_strobe, addr, wdata);
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			next_cycle();
		repeat (6) next_cycle();
	endtask

	task automatic download(input int len, input logic [63:0] id);
		word_t       w;
		logic [63:0] seen;
		drain();
		dl_active = 1'b1;
		m_mask = '0;
		for (int i = 0; i < len; i++) begin
			w = word_t'($urandom);
			if (i >= ID_FIRST_WORD && i < ID_FIRST_WORD + ID_WORDS)
				w = id[63 - 16 * (i - ID_FIRST_WORD) -: 16];
			m_rom[i] = w;
			m_mask = m_mask | rom_addr_t'(i);
			dl_valid = 1'b1;
			dl_addr = rom_addr_t'(i);
			dl_data = w;
			next_cycle();
		end
		dl_valid = 1'b0;
		dl_active = 1'b0;
		m_size = len;
		seen = {m_rom[193], m_rom[194], m_rom[195], m_rom[196]};
		m_sram_quirk = (seen == "T-081276");
		m_noram_quirk = (seen == "T-113016");
		repeat (4) next_cycle();
	endtask

	// Percent weights for ROM, SRAM window and register traffic
	// Whatever is left goes to open space
	task automatic random_req(input int p_rom, input int p_sram, input int p_reg,
			input int reg_first);
		int        pick;
		logic      write;
		word_t     wdata;
		bus_addr_t addr;
		pick = $urandom % 100;
		write = ($urandom % 2) == 1;
		wdata = word_t'($urandom);
		if (pick < p_rom) begin
			addr = bus_addr_t'($urandom % ROM_WINDOW_WORDS);
			send_req(($urandom % 8) == 0, 1'b0, addr, wdata);
		end else if (pick < p_rom + p_sram) begin
			addr = bus_addr_t'(SRAM_BASE + $urandom % 2**SRAM_AW);
			send_req(write, 1'b0, addr, wdata);
		end else if (pick < p_rom + p_sram + p_reg) begin
			addr = bus_addr_t'(($urandom << 3) | (reg_first + $urandom % (8 - reg_first)));
			send_req(1'b1, 1'b1, addr, wdata);
		end else begin
			if (($urandom % 4) == 0)
				addr = bus_addr_t'(SRAM_QUIRK_ADDR);
			else
				addr = bus_addr_t'(OPEN_BASE + $urandom % (2**23 - OPEN_BASE));
			send_req(write, 1'b0, addr, wdata);
		end
	endtask

	initial begin
		void'($urandom(32'hbab6_6899));
		clk = 1'b0;
		reset = 1'b1;
		dl_active = 1'b0;
		dl_valid = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_reg = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		rsp_ready = 1'b1;
		stall_on = 1'b0;
		errors = 0;
		n_checks = 0;
		cycles = 0;
		m_banks_used = 1'b0;
		m_sram_en = 1'b0;
		m_sram_quirk = 1'b0;
		m_noram_quirk = 1'b0;
		m_size = 0;
		m_mask = '0;
		for (int i = 0; i < 8; i++)
			m_bank[i] = bank_t'(i);
		repeat (16) @(negedge clk);
		reset = 1'b0;
		next_cycle();

		// Small image, SRAM open by size, filled first
		download(LEN_SMALL, "GM 00001");
		for (int i = 0; i < 2**SRAM_AW; i++)
			send_req(1'b1, 1'b0, bus_addr_t'(SRAM_BASE + i), word_t'((i * 7) ^ (i >> 3)));
		repeat (300) random_req(50, 35, 0, 0);

		// Large image, SRAM behind register 0, then banking
		download(LEN_LARGE, "GM 00002");
		repeat (20) random_req(0, 100, 0, 0);
		send_req(1'b1, 1'b1, bus_addr_t'(0), 16'h0001);
		repeat (20) random_req(0, 100, 0, 0);
		repeat (600) random_req(70, 0, 30, 1);

		// Forced SRAM alias title
		download(LEN_MID, "T-081276");
		send_req(1'b1, 1'b0, bus_addr_t'(SRAM_QUIRK_ADDR), 16'h00c3);
		send_req(1'b0, 1'b0, bus_addr_t'(SRAM_QUIRK_ADDR), '0);
		send_req(1'b0, 1'b0, bus_addr_t'(SRAM_BASE + 1023), '0);
		repeat (200) random_req(40, 20, 10, 0);

		// No-RAM title with a stalling response side
		download(LEN_SMALL, "T-113016");
		stall_on = 1'b1;
		send_req(1'b1, 1'b1, bus_addr_t'(0), 16'h0000);
		repeat (100) random_req(30, 50, 0, 0);

		// Large image, every kind of request
		download(LEN_LARGE, "GM 00005");
		repeat (800) random_req(40, 25, 15, 0);
		drain();

		errors += dut.u_pipe_chk.fail_count;
		$display("Finished: %0d reads checked, %0d errors", n_checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
